//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= processorTb
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Verification passed" $(LOG) && echo "Simulation PASS" || \
		(echo "Simulation FAIL"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- include/coreCfg.svh
// Core configuration
// Word, address and register file sizes shared by the package and the RTL.

`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

`define CORE_DATA_WIDTH     32  // data word
`define CORE_ADDR_WIDTH     16  // word address
`define CORE_REG_COUNT      32
`define CORE_REG_ADDR_WIDTH 5

`endif

//--- logic/corePkg.sv
// Core package
// Word types, ISA encodings and the layouts of the pipeline registers.

`include "coreCfg.svh"

package corePkg;

    typedef logic [`CORE_DATA_WIDTH-1:0]     word_t;
    typedef logic [`CORE_ADDR_WIDTH-1:0]     addr_t;
    typedef logic [`CORE_REG_ADDR_WIDTH-1:0] regAddr_t;
    typedef logic [31:0]                     instr_t;
    typedef logic [3:0]                      aluFunc_t;
    typedef logic [1:0]                      fwdSel_t;

    ////////////////////////////////////////
    // opcodes and function fields

    localparam logic [5:0] opRType = 6'h00;
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opBne   = 6'h05;
    localparam logic [5:0] opAddi  = 6'h08;
    localparam logic [5:0] opAndi  = 6'h0c;
    localparam logic [5:0] opOri   = 6'h0d;
    localparam logic [5:0] opLui   = 6'h0f;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;

    localparam logic [5:0] funcSll = 6'h00;
    localparam logic [5:0] funcSrl = 6'h02;
    localparam logic [5:0] funcAdd = 6'h20;
    localparam logic [5:0] funcSub = 6'h22;
    localparam logic [5:0] funcAnd = 6'h24;
    localparam logic [5:0] funcOr  = 6'h25;
    localparam logic [5:0] funcXor = 6'h26;
    localparam logic [5:0] funcSlt = 6'h2a;

    localparam aluFunc_t aluAdd = 4'd0;
    localparam aluFunc_t aluSub = 4'd1;
    localparam aluFunc_t aluAnd = 4'd2;
    localparam aluFunc_t aluOr  = 4'd3;
    localparam aluFunc_t aluXor = 4'd4;
    localparam aluFunc_t aluSlt = 4'd5;
    localparam aluFunc_t aluSll = 4'd6;
    localparam aluFunc_t aluSrl = 4'd7;
    localparam aluFunc_t aluLui = 4'd8;

    localparam fwdSel_t fwdNone = 2'd0;
    localparam fwdSel_t fwdMem  = 2'd1;  // from memory stage
    localparam fwdSel_t fwdWb   = 2'd2;  // from writeback

    ////////////////////////////////////////
    // pipeline registers

    typedef struct packed {
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
        logic     memToReg;
        logic     aluSrcImm;
        logic     branch;
        logic     branchNe;
        logic     jump;
        aluFunc_t aluFunc;
    } ctrl_t;

    typedef struct packed {
        ctrl_t      ctrl;
        addr_t      pc;
        word_t      rsData;
        word_t      rtData;
        word_t      imm;
        regAddr_t   rsAddr;
        regAddr_t   rtAddr;
        regAddr_t   destAddr;
        logic [4:0] shamt;
        addr_t      target;
    } idEx_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    aluResult;
        word_t    storeData;
        regAddr_t rtAddr;
        regAddr_t destAddr;
    } exMem_t;

    typedef struct packed {
        logic     regWrite;
        logic     memToReg;
        word_t    aluResult;
        word_t    loadData;
        regAddr_t destAddr;
    } memWb_t;

endpackage

//--- logic/decodeStage.sv
// Decode stage
// Sorts the opcode into an instruction class, builds the control word
// and immediate, and reads both operands from the register file.

`timescale 1ns/1ps

module decodeStage (
    input  logic              Clock,
    input  logic              nReset,
    input  corePkg::instr_t   instruction,
    input  corePkg::addr_t    pc,
    input  logic              wbWrite,
    input  corePkg::regAddr_t wbAddr,
    input  corePkg::word_t    wbData,
    input  corePkg::regAddr_t RegAddr,
    output corePkg::word_t    RegData,
    output corePkg::idEx_t    decoded
);
    import corePkg::*;

    typedef enum logic [2:0] {
        clsReg,
        clsImm,
        clsLoad,
        clsStore,
        clsBranch,
        clsJump,
        clsIllegal
    } instrClass_t;

    instrClass_t instrClass;
    logic [5:0]  opcode;
    logic [5:0]  funct;
    regAddr_t    rs;
    regAddr_t    rt;
    regAddr_t    rd;
    word_t       rsData;
    word_t       rtData;
    ctrl_t       ctrl;
    logic        zeroExt;

    assign opcode  = instruction[31:26];
    assign rs      = instruction[25:21];
    assign rt      = instruction[20:16];
    assign rd      = instruction[15:11];
    assign funct   = instruction[5:0];
    assign zeroExt = (opcode == opAndi) || (opcode == opOri);

    registerFile registerFile_inst (
        .Clock       (Clock),
        .nReset      (nReset),
        .writeEnable (wbWrite),
        .writeAddr   (wbAddr),
        .writeData   (wbData),
        .rsAddr      (rs),
        .rtAddr      (rt),
        .RegAddr     (RegAddr),
        .rsData      (rsData),
        .rtData      (rtData),
        .RegData     (RegData)
    );

    always_comb begin
        case (opcode)
            opRType:                      instrClass = clsReg;
            opAddi, opAndi, opOri, opLui: instrClass = clsImm;
            opLw:                         instrClass = clsLoad;
            opSw:                         instrClass = clsStore;
            opBeq, opBne:                 instrClass = clsBranch;
            opJ:                          instrClass = clsJump;
            default:                      instrClass = clsIllegal;
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (instrClass)
            clsReg: begin
                ctrl.regWrite = 1'b1;
                case (funct)
                    funcAdd: ctrl.aluFunc = aluAdd;
                    funcSub: ctrl.aluFunc = aluSub;
                    funcAnd: ctrl.aluFunc = aluAnd;
                    funcOr:  ctrl.aluFunc = aluOr;
                    funcXor: ctrl.aluFunc = aluXor;
                    funcSlt: ctrl.aluFunc = aluSlt;
                    funcSll: ctrl.aluFunc = aluSll;
                    funcSrl: ctrl.aluFunc = aluSrl;
                    default: ctrl.regWrite = 1'b0;  // unknown function, bubble
                endcase
            end
            clsImm: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                case (opcode)
                    opAndi:  ctrl.aluFunc = aluAnd;
                    opOri:   ctrl.aluFunc = aluOr;
                    opLui:   ctrl.aluFunc = aluLui;
                    default: ctrl.aluFunc = aluAdd;
                endcase
            end
            clsLoad: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluFunc   = aluAdd;  // base plus offset
            end
            clsStore: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluFunc   = aluAdd;
            end
            clsBranch: begin
                ctrl.branch   = 1'b1;
                ctrl.branchNe = (opcode == opBne);
                ctrl.aluFunc  = aluSub;
            end
            clsJump: ctrl.jump = 1'b1;
            default: ctrl = '0;  // illegal opcode
        endcase
    end

    always_comb begin
        decoded.ctrl     = ctrl;
        decoded.pc       = pc;
        decoded.rsData   = rsData;
        decoded.rtData   = rtData;
        decoded.imm      = zeroExt ? {16'h0000, instruction[15:0]}
                                   : {{16{instruction[15]}}, instruction[15:0]};
        decoded.rsAddr   = rs;
        decoded.rtAddr   = rt;
        decoded.destAddr = (instrClass == clsReg) ? rd : rt;
        decoded.shamt    = instruction[10:6];
        decoded.target   = addr_t'(instruction[25:0]);  // low bits of index
    end

endmodule

//--- logic/executeStage.sv
// Execute stage
// Operand forwarding, the ALU and branch and jump resolution.

`timescale 1ns/1ps

module executeStage (
    input  corePkg::idEx_t   stage,
    input  corePkg::fwdSel_t fwdA,
    input  corePkg::fwdSel_t fwdB,
    input  corePkg::word_t   memResult,
    input  corePkg::word_t   wbResult,
    output corePkg::exMem_t  result,
    output logic             redirect,
    output corePkg::addr_t   redirectTarget
);
    import corePkg::*;

    word_t opA;
    word_t rtValue;
    word_t opB;
    word_t aluOut;
    logic  taken;

    function automatic word_t forward(input fwdSel_t sel, input word_t regValue,
                                      input word_t memValue, input word_t wbValue);
        case (sel)
            fwdMem:  return memValue;
            fwdWb:   return wbValue;
            default: return regValue;
        endcase
    endfunction

    assign opA     = forward(fwdA, stage.rsData, memResult, wbResult);
    assign rtValue = forward(fwdB, stage.rtData, memResult, wbResult);
    assign opB     = stage.ctrl.aluSrcImm ? stage.imm : rtValue;

    always_comb begin
        case (stage.ctrl.aluFunc)
            aluAdd:  aluOut = opA + opB;
            aluSub:  aluOut = opA - opB;
            aluAnd:  aluOut = opA & opB;
            aluOr:   aluOut = opA | opB;
            aluXor:  aluOut = opA ^ opB;
            aluSlt:  aluOut = word_t'($signed(opA) < $signed(opB));
            aluSll:  aluOut = opB << stage.shamt;
            aluSrl:  aluOut = opB >> stage.shamt;
            aluLui:  aluOut = {stage.imm[15:0], 16'h0000};
            default: aluOut = '0;
        endcase
    end

    // beq and bne compare the forwarded register operands
    assign taken    = stage.ctrl.branch && ((opA == rtValue) != stage.ctrl.branchNe);
    assign redirect = taken || stage.ctrl.jump;

    assign redirectTarget = stage.ctrl.jump ? stage.target
                                            : stage.pc + addr_t'(1) + addr_t'(stage.imm);

    always_comb begin
        result.ctrl      = stage.ctrl;
        result.aluResult = aluOut;
        result.storeData = rtValue;  // forwarded store data
        result.rtAddr    = stage.rtAddr;
        result.destAddr  = stage.destAddr;
    end

endmodule

//--- logic/fetchStage.sv
// Fetch stage
// Program counter with stall hold and branch or jump redirect.

`timescale 1ns/1ps

module fetchStage (
    input  logic           Clock,
    input  logic           nReset,
    input  logic           nStall,
    input  logic           redirect,
    input  corePkg::addr_t redirectTarget,
    output corePkg::addr_t InstrAddr
);
    import corePkg::*;

    addr_t pcNext;

    always_comb begin
        if (redirect)
            pcNext = redirectTarget;  // wins over a stall
        else if (!nStall)
            pcNext = InstrAddr;
        else
            pcNext = InstrAddr + addr_t'(1);
    end

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset)
            InstrAddr <= '0;
        else
            InstrAddr <= pcNext;
    end

endmodule

//--- logic/hazardUnit.sv
// Hazard unit
// Forwarding selects for execute and the load-use stall.

`timescale 1ns/1ps

module hazardUnit (
    input  corePkg::regAddr_t rsAddrEx,
    input  corePkg::regAddr_t rtAddrEx,
    input  logic              memRegWrite,
    input  corePkg::regAddr_t memDestAddr,
    input  logic              wbRegWrite,
    input  corePkg::regAddr_t wbDestAddr,
    input  logic              exMemRead,
    input  corePkg::regAddr_t exDestAddr,
    input  corePkg::regAddr_t rsAddrDec,
    input  corePkg::regAddr_t rtAddrDec,
    output corePkg::fwdSel_t  fwdA,
    output corePkg::fwdSel_t  fwdB,
    output logic              nStall
);
    import corePkg::*;

    logic loadUse;

    // youngest producer first
    function automatic fwdSel_t pick(input regAddr_t src);
        if (src == '0)
            return fwdNone;
        else if (memRegWrite && memDestAddr == src)
            return fwdMem;
        else if (wbRegWrite && wbDestAddr == src)
            return fwdWb;
        else
            return fwdNone;
    endfunction

    always_comb begin
        fwdA = pick(rsAddrEx);
        fwdB = pick(rtAddrEx);
    end

    assign loadUse = exMemRead && (exDestAddr != '0)
                     && (exDestAddr == rsAddrDec || exDestAddr == rtAddrDec);
    assign nStall  = !loadUse;

endmodule

//--- logic/processor.sv
// Five-stage pipelined processor core
// Holds the pipeline registers, applies stall and flush, drives the
// data memory interface and selects the writeback data.

`timescale 1ns/1ps

module processor (
    input  logic              Clock,
    input  logic              nReset,
    input  corePkg::instr_t   InstrMem,
    input  corePkg::word_t    MemData,
    input  corePkg::regAddr_t RegAddr,
    output corePkg::word_t    WriteData,
    output corePkg::word_t    RegData,
    output corePkg::addr_t    InstrAddr,
    output corePkg::addr_t    MemAddr,
    output logic              MemWrite,
    output logic              MemRead,
    output logic              nStall
);
    import corePkg::*;

    instr_t  decInstr;
    addr_t   decPc;
    idEx_t   decoded;
    idEx_t   idExNext;
    idEx_t   idEx;
    exMem_t  exResult;
    exMem_t  exMem;
    memWb_t  memWb;
    fwdSel_t fwdA;
    fwdSel_t fwdB;
    word_t   wbData;
    logic    redirect;
    addr_t   redirectTarget;

    ////////////////////////////////////////
    // fetch

    fetchStage fetchStage_inst (
        .Clock          (Clock),
        .nReset         (nReset),
        .nStall         (nStall),
        .redirect       (redirect),
        .redirectTarget (redirectTarget),
        .InstrAddr      (InstrAddr)
    );

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            decInstr <= '0;
            decPc    <= '0;
        end else if (redirect) begin
            decInstr <= '0;  // squashed to a nop
            decPc    <= '0;
        end else if (nStall) begin
            decInstr <= InstrMem;
            decPc    <= InstrAddr;
        end
    end

    ////////////////////////////////////////
    // decode

    decodeStage decodeStage_inst (
        .Clock       (Clock),
        .nReset      (nReset),
        .instruction (decInstr),
        .pc          (decPc),
        .wbWrite     (memWb.regWrite),
        .wbAddr      (memWb.destAddr),
        .wbData      (wbData),
        .RegAddr     (RegAddr),
        .RegData     (RegData),
        .decoded     (decoded)
    );

    always_comb begin
        idExNext = decoded;
        if (redirect || !nStall)
            idExNext.ctrl = '0;  // bubble into execute
    end

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset)
            idEx <= '0;
        else
            idEx <= idExNext;
    end

    ////////////////////////////////////////
    // execute

    hazardUnit hazardUnit_inst (
        .rsAddrEx    (idEx.rsAddr),
        .rtAddrEx    (idEx.rtAddr),
        .memRegWrite (exMem.ctrl.regWrite),
        .memDestAddr (exMem.destAddr),
        .wbRegWrite  (memWb.regWrite),
        .wbDestAddr  (memWb.destAddr),
        .exMemRead   (idEx.ctrl.memRead),
        .exDestAddr  (idEx.destAddr),
        .rsAddrDec   (decoded.rsAddr),
        .rtAddrDec   (decoded.rtAddr),
        .fwdA        (fwdA),
        .fwdB        (fwdB),
        .nStall      (nStall)
    );

    executeStage executeStage_inst (
        .stage          (idEx),
        .fwdA           (fwdA),
        .fwdB           (fwdB),
        .memResult      (exMem.aluResult),
        .wbResult       (wbData),
        .result         (exResult),
        .redirect       (redirect),
        .redirectTarget (redirectTarget)
    );

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset)
            exMem <= '0;
        else
            exMem <= exResult;
    end

    ////////////////////////////////////////
    // memory and writeback

    assign MemAddr   = addr_t'(exMem.aluResult);
    assign WriteData = exMem.storeData;
    assign MemWrite  = exMem.ctrl.memWrite;
    assign MemRead   = exMem.ctrl.memRead;

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            memWb <= '0;
        end else begin
            memWb.regWrite  <= exMem.ctrl.regWrite;
            memWb.memToReg  <= exMem.ctrl.memToReg;
            memWb.aluResult <= exMem.aluResult;
            memWb.loadData  <= MemData;  // same-cycle read data
            memWb.destAddr  <= exMem.destAddr;
        end
    end

    assign wbData = memWb.memToReg ? memWb.loadData : memWb.aluResult;

endmodule

//--- logic/registerFile.sv
// Register file
// 32 general registers, register 0 tied to zero. A write shows through
// on all read ports in the cycle it happens, including the debug port.

`timescale 1ns/1ps

`include "coreCfg.svh"

module registerFile (
    input  logic              Clock,
    input  logic              nReset,
    input  logic              writeEnable,
    input  corePkg::regAddr_t writeAddr,
    input  corePkg::word_t    writeData,
    input  corePkg::regAddr_t rsAddr,
    input  corePkg::regAddr_t rtAddr,
    input  corePkg::regAddr_t RegAddr,
    output corePkg::word_t    rsData,
    output corePkg::word_t    rtData,
    output corePkg::word_t    RegData
);
    import corePkg::*;

    word_t regs [`CORE_REG_COUNT];

    function automatic word_t readPort(input regAddr_t addr);
        if (addr == '0)
            return '0;
        else if (writeEnable && writeAddr == addr)
            return writeData;  // write-first
        else
            return regs[addr];
    endfunction

    always_comb begin
        rsData  = readPort(rsAddr);
        rtData  = readPort(rtAddr);
        RegData = readPort(RegAddr);
    end

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++)
                regs[i] <= '0;
        end else if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

endmodule

//--- testbench/processorTb.sv
// Processor testbench
// Models the instruction and data memories, runs short directed programs
// and reads the results back through the debug register port.

`timescale 1ns/1ps

module processorTb;
    import corePkg::*;

    localparam int maxCycles = 2000;  // the tests need roughly 300

    logic     Clock;
    logic     nReset;
    instr_t   InstrMem;
    word_t    MemData;
    regAddr_t RegAddr;
    word_t    WriteData;
    word_t    RegData;
    addr_t    InstrAddr;
    addr_t    MemAddr;
    logic     MemWrite;
    logic     MemRead;
    logic     nStall;

    instr_t imem [256];
    word_t  dmem [256];
    int     progAddr;
    int     cycleCount = 0;
    int     stallCount = 0;
    int     readCount  = 0;

    processor processor_inst (
        .Clock     (Clock),
        .nReset    (nReset),
        .InstrMem  (InstrMem),
        .MemData   (MemData),
        .RegAddr   (RegAddr),
        .WriteData (WriteData),
        .RegData   (RegData),
        .InstrAddr (InstrAddr),
        .MemAddr   (MemAddr),
        .MemWrite  (MemWrite),
        .MemRead   (MemRead),
        .nStall    (nStall)
    );

    initial begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock;
    end

    ////////////////////////////////////////
    // memory models

    assign InstrMem = imem[InstrAddr[7:0]];  // asynchronous reads
    assign MemData  = dmem[MemAddr[7:0]];

    initial begin
        void'($urandom(32'h9fc5));
        for (int i = 0; i < 256; i++)
            dmem[i] <= $urandom;
        forever begin
            @(posedge Clock);
            if (MemWrite)
                dmem[MemAddr[7:0]] <= WriteData;
        end
    end

    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= maxCycles)
            failRun($sformatf("Timeout: run exceeded %0d cycles", maxCycles));
    end

    always @(negedge Clock)
        if (nReset && !nStall)
            stallCount <= stallCount + 1;  // load-use bubbles seen

    always @(negedge Clock)
        if (nReset && MemRead)
            readCount <= readCount + 1;  // load strobes seen

    ////////////////////////////////////////
    // encoders and helpers

    function automatic instr_t rType(input logic [5:0] funct, input int rd, input int rs,
                                     input int rt, input int shamt);
        return {opRType, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), funct};
    endfunction

    function automatic instr_t iType(input logic [5:0] op, input int rt, input int rs,
                                     input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic instr_t jType(input int target);
        return {opJ, 26'(target)};
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input word_t got, input word_t expected);
        assert (got === expected)
        else failRun($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, expected));
    endtask

    task automatic checkReg(input int r, input word_t expected);
        @(posedge Clock);
        RegAddr <= 5'(r);
        @(negedge Clock);
        checkValue($sformatf("RegData[r%0d]", r), RegData, expected);
    endtask

    task automatic clearProgram();
        for (int i = 0; i < 256; i++)
            imem[i] = '0;  // sll r0 is a nop
        progAddr = 0;
    endtask

    task automatic emit(input instr_t word);
        imem[progAddr] = word;
        progAddr++;
    endtask

    task automatic park();
        emit(jType(progAddr));  // self-jump
    endtask

    task automatic resetCore();
        @(posedge Clock);
        nReset <= 1'b0;
        repeat (4) @(posedge Clock);
        nReset <= 1'b1;
    endtask

    ////////////////////////////////////////
    // directed tests

    task automatic arithmeticTest();
        word_t a;
        word_t b;
        a = 32'h0000_1234;
        b = word_t'(-7);
        clearProgram();
        emit(iType(opAddi, 1, 0, 'h1234));
        emit(iType(opAddi, 2, 0, -7));
        emit(iType(opAddi, 0, 0, 5));  // r0 must stay zero
        emit('0);
        emit('0);
        emit('0);
        emit(rType(funcAdd, 3, 1, 2, 0));
        emit(rType(funcSub, 4, 1, 2, 0));
        emit(rType(funcAnd, 5, 1, 2, 0));
        emit(rType(funcOr, 6, 1, 2, 0));
        emit(rType(funcXor, 7, 1, 2, 0));
        emit(rType(funcSlt, 8, 2, 1, 0));
        emit(rType(funcSlt, 9, 1, 2, 0));
        emit(rType(funcSll, 10, 0, 1, 4));
        emit(rType(funcSrl, 11, 0, 2, 8));
        emit(iType(opLui, 12, 0, 'habcd));
        emit(iType(opAndi, 13, 2, 'h00f0));  // zero-extended
        emit(iType(opOri, 14, 0, 'h8001));
        park();
        resetCore();
        repeat (30) @(posedge Clock);
        checkReg(0, '0);
        checkReg(1, a);
        checkReg(2, b);
        checkReg(3, a + b);
        checkReg(4, a - b);
        checkReg(5, a & b);
        checkReg(6, a | b);
        checkReg(7, a ^ b);
        checkReg(8, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        checkReg(9, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        checkReg(10, a << 4);
        checkReg(11, b >> 8);
        checkReg(12, {16'habcd, 16'h0000});
        checkReg(13, b & 32'h0000_00f0);
        checkReg(14, 32'h0000_8001);
    endtask

    task automatic forwardingTest();
        clearProgram();
        emit(iType(opAddi, 1, 0, 3));
        emit(rType(funcAdd, 2, 1, 1, 0));   // from memory stage
        emit(rType(funcAdd, 3, 2, 1, 0));
        emit(iType(opAddi, 4, 0, 10));
        emit('0);
        emit(rType(funcAdd, 5, 4, 4, 0));   // from writeback
        emit(iType(opAddi, 6, 0, 11));
        emit('0);
        emit('0);
        emit(rType(funcAdd, 7, 6, 6, 0));   // register file bypass
        emit(iType(opAddi, 8, 0, 12));
        emit('0);
        emit('0);
        emit('0);
        emit(rType(funcAdd, 9, 8, 8, 0));
        emit(rType(funcSub, 10, 9, 7, 0));
        emit(rType(funcAdd, 11, 10, 9, 0));
        park();
        resetCore();
        repeat (30) @(posedge Clock);
        checkReg(2, 32'd6);
        checkReg(3, 32'd9);
        checkReg(5, 32'd20);
        checkReg(7, 32'd22);
        checkReg(9, 32'd24);
        checkReg(10, 32'd24 - 32'd22);
        checkReg(11, (32'd24 - 32'd22) + 32'd24);
    endtask

    task automatic loadStoreTest();
        word_t base;
        word_t stored;
        word_t randomWord;
        int    stallStart;
        int    readStart;
        base       = 32'h0000_05a5;
        stored     = base << 8;
        randomWord = dmem[40];
        clearProgram();
        emit(iType(opAddi, 1, 0, 'h05a5));
        emit(rType(funcSll, 2, 0, 1, 8));
        emit(iType(opSw, 2, 0, 16));
        emit(iType(opLw, 3, 0, 16));
        emit(iType(opLw, 4, 0, 40));
        emit(iType(opLw, 5, 0, 16));
        emit(rType(funcAdd, 6, 5, 1, 0));   // load-use pair
        emit(iType(opAddi, 7, 6, 1));
        park();
        stallStart = stallCount;
        readStart  = readCount;
        resetCore();
        repeat (30) @(posedge Clock);
        assert (stallCount > stallStart)
        else failRun("nStall never went low during the load-use sequence");
        checkValue("MemRead cycles", word_t'(readCount - readStart), 32'd3);  // one per load
        checkValue("dmem[16]", dmem[16], stored);
        checkReg(3, stored);
        checkReg(4, randomWord);
        checkReg(6, stored + base);
        checkReg(7, stored + base + 32'd1);
    endtask

    task automatic branchTest();
        int loopCount;
        loopCount = 5;
        clearProgram();
        emit(iType(opAddi, 1, 0, 1));
        emit(iType(opAddi, 2, 0, 1));
        emit(iType(opAddi, 3, 0, 2));
        emit(iType(opBeq, 2, 1, 2));        // taken to 6
        emit(iType(opAddi, 10, 0, 'hbad));
        emit(iType(opAddi, 11, 0, 'hbad));
        emit(iType(opBne, 3, 1, 1));        // taken to 8
        emit(iType(opAddi, 12, 0, 'hbad));
        emit(iType(opBeq, 3, 1, 1));        // not taken
        emit(iType(opAddi, 13, 0, 'h11));
        emit(iType(opBne, 2, 1, 1));        // not taken
        emit(iType(opAddi, 14, 0, 'h22));
        emit(iType(opAddi, 4, 0, loopCount));
        emit(iType(opAddi, 5, 0, 0));
        emit(iType(opAddi, 5, 5, 1));       // loop top at 14
        emit(iType(opAddi, 4, 4, -1));
        emit(iType(opBne, 0, 4, -3));
        emit(iType(opAddi, 15, 0, 'h33));
        park();
        resetCore();
        repeat (80) @(posedge Clock);
        checkReg(10, '0);
        checkReg(11, '0);
        checkReg(12, '0);
        checkReg(13, 32'h11);
        checkReg(14, 32'h22);
        checkReg(4, '0);
        checkReg(5, word_t'(loopCount));
        checkReg(15, 32'h33);
    endtask

    task automatic jumpTest();
        clearProgram();
        emit(iType(opAddi, 1, 0, 7));
        emit(jType(5));
        emit(iType(opAddi, 2, 0, 'hbad));
        emit(iType(opAddi, 3, 0, 'hbad));
        emit(iType(opAddi, 4, 0, 'hbad));
        emit(iType(opAddi, 5, 1, 1));       // jump lands here
        park();
        resetCore();
        repeat (25) @(posedge Clock);
        checkReg(2, '0);
        checkReg(3, '0);
        checkReg(4, '0);
        checkReg(5, 32'd8);
    endtask

    task automatic resetTest();
        clearProgram();
        emit(iType(opAddi, 1, 0, 'h77));
        emit(iType(opAddi, 2, 0, 20));
        emit('0);
        emit(iType(opSw, 1, 2, 0));         // first store, fetched in cycle 3
        park();
        resetCore();
        for (int cyc = 0; cyc <= 6; cyc++) begin
            @(negedge Clock);
            if (cyc == 0) begin
                checkValue("InstrAddr", word_t'(InstrAddr), '0);
                checkValue("nStall", word_t'(nStall), 32'd1);
            end
            checkValue("MemWrite", word_t'(MemWrite), (cyc == 6) ? 32'd1 : 32'd0);
        end
        checkValue("MemAddr", word_t'(MemAddr), 32'd20);
        checkValue("WriteData", WriteData, 32'h77);
    endtask

    initial begin
        nReset  = 1'b0;
        RegAddr = '0;
        arithmeticTest();
        forwardingTest();
        loadStoreTest();
        branchTest();
        jumpTest();
        resetTest();
        $display("Verification passed");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+include
logic/corePkg.sv
logic/fetchStage.sv
logic/registerFile.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/hazardUnit.sv
logic/processor.sv
testbench/processorTb.sv
